// File: Makefile
VERILATOR ?= verilator
TOP ?= conv_tb
FILELIST ?= conv3x3.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "SIMULATION FAILED" >> $(LOG)
	@cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: booth_multiplier.sv
`timescale 1ns/1ps
`include "conv_cfg.svh"

module booth_multiplier
	import conv_pkg::*;
(
	input  coef_t  a,
	input  pixel_t b,
	output acc_t   p
);

	// nine digits cover the coefficient plus two sign copies
	localparam int digit_n = (`CONV_DATA_W + 2) / 2;
	localparam int ext_w = 2 * digit_n + 1;

	logic [ext_w-1:0] a_ext;
	logic [2:0] digit [digit_n];
	prod_t pp [digit_n];

	// carry-save levels, 9 -> 6 -> 4 -> 3 -> 2
	prod_t s1 [3];
	prod_t c1 [3];
	prod_t s2 [2];
	prod_t c2 [2];
	prod_t s3;
	prod_t c3;
	prod_t s4;
	prod_t c4;
	prod_t prod;

	// one radix-4 digit times the pixel, sign-extended to full width
	function automatic prod_t booth_pp(input logic [2:0] code, input pixel_t m);
		prod_t m_ext;
		m_ext = prod_t'(m);
		case (code)
			3'b001, 3'b010: booth_pp = m_ext;
			3'b011: booth_pp = m_ext <<< 1;
			3'b100: booth_pp = -(m_ext <<< 1);
			3'b101, 3'b110: booth_pp = -m_ext;
			// 000 and 111 are zero
			default: booth_pp = '0;
		endcase
	endfunction

	// full adder per bit, sum half
	function automatic prod_t csa_sum(input prod_t x, input prod_t y, input prod_t z);
		csa_sum = x ^ y ^ z;
	endfunction

	// full adder per bit, carry half already weighted by 2
	function automatic prod_t csa_carry(input prod_t x, input prod_t y, input prod_t z);
		csa_carry = ((x & y) | (x & z) | (y & z)) << 1;
	endfunction

	// implicit zero below bit 0
	assign a_ext = {a[`CONV_DATA_W-1], a[`CONV_DATA_W-1], a, 1'b0};

	always_comb begin
		for (int i = 0; i < digit_n; i++) begin
			digit[i] = a_ext[2*i +: 3];
			pp[i] = booth_pp(digit[i], b) <<< (2 * i);
		end
	end

	// level 1, three groups of three rows
	always_comb begin
		for (int g = 0; g < 3; g++) begin
			s1[g] = csa_sum(pp[3*g], pp[3*g+1], pp[3*g+2]);
			c1[g] = csa_carry(pp[3*g], pp[3*g+1], pp[3*g+2]);
		end
	end

	// level 2
	assign s2[0] = csa_sum(s1[0], c1[0], s1[1]);
	assign c2[0] = csa_carry(s1[0], c1[0], s1[1]);
	assign s2[1] = csa_sum(c1[1], s1[2], c1[2]);
	assign c2[1] = csa_carry(c1[1], s1[2], c1[2]);

	// level 3
	assign s3 = csa_sum(s2[0], c2[0], s2[1]);
	assign c3 = csa_carry(s2[0], c2[0], s2[1]);

	// level 4, last row folded in
	assign s4 = csa_sum(s3, c3, c2[1]);
	assign c4 = csa_carry(s3, c3, c2[1]);

	// final carry-propagate add, wraps modulo 2^32
	assign prod = s4 + c4;

	// sign bit, then the 15 bits just above the 1.0 position
	assign p = {prod[`CONV_PROD_W-1], prod[`CONV_TRUNC_HI:`CONV_TRUNC_LO]};

endmodule

// File: conv3x3.f
+incdir+.
conv_pkg.sv
conv_window_if.sv
load_sequencer.sv
window_buffer.sv
booth_multiplier.sv
mac_tree.sv
conv3x3_engine.sv
conv_checker.sv
conv_assertions.sv
conv_tb.sv

// File: conv3x3_engine.sv
`timescale 1ns/1ps
`include "conv_cfg.svh"

module conv3x3_engine
	import conv_pkg::*;
(
	input  logic  clk,
	input  logic  rst_n,
	input  logic  req,
	input  word_t data,
	output logic  ack,
	output acc_t  result,
	output logic  result_valid,
	output logic  finish
);

	// sequencer to window buffer
	word_t word;
	logic coef_we;
	logic pix_we;

	// kernel and window to the multipliers
	conv_window_if u_win ();

	load_sequencer u_load_sequencer (
		.clk     (clk),
		.rst_n   (rst_n),
		.req     (req),
		.data    (data),
		.ack     (ack),
		.word    (word),
		.coef_we (coef_we),
		.pix_we  (pix_we)
	);

	window_buffer #(
		.img_n (`CONV_IMG_N)
	) u_window_buffer (
		.clk     (clk),
		.rst_n   (rst_n),
		.word    (word),
		.coef_we (coef_we),
		.pix_we  (pix_we),
		.win     (u_win.src)
	);

	mac_tree u_mac_tree (
		.clk          (clk),
		.rst_n        (rst_n),
		.win          (u_win.dst),
		.result       (result),
		.result_valid (result_valid),
		.finish       (finish)
	);

endmodule

// File: conv_assertions.sv
`timescale 1ns/1ps

module conv_assertions (
	input logic       clk,
	input logic       rst_n,
	input logic       req,
	input logic       ack,
	input logic [1:0] strobe,
	input logic       result_valid,
	input logic       finish
);

	// number of failed checks so far
	int fail_count = 0;

	// ack only answers a pending request
	a_ack_rise: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(ack) |-> $past(req))
		else begin
			$error("ack rose while req was low");
			fail_count++;
		end

	// release phase, ack waits for req to drop
	a_ack_fall: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(ack) |-> !$past(req))
		else begin
			$error("ack fell while req was still high");
			fail_count++;
		end

	// exactly one write strobe per handshake, never both kinds
	a_one_strobe: assert property (@(posedge clk) disable iff (!rst_n)
		((|strobe) == $rose(ack)) && $onehot0(strobe))
		else begin
			$error("write strobe not paired with a single ack rise");
			fail_count++;
		end

	a_finish_valid: assert property (@(posedge clk) disable iff (!rst_n)
		finish |-> result_valid)
		else begin
			$error("finish high without result_valid");
			fail_count++;
		end

endmodule

// handshake side
bind load_sequencer conv_assertions u_seq_assertions (
	.clk          (clk),
	.rst_n        (rst_n),
	.req          (req),
	.ack          (ack),
	.strobe       ({coef_we, pix_we}),
	.result_valid (1'b0),
	.finish       (1'b0)
);

// output side
bind mac_tree conv_assertions u_mac_assertions (
	.clk          (clk),
	.rst_n        (rst_n),
	.req          (1'b0),
	.ack          (1'b0),
	.strobe       (2'b00),
	.result_valid (result_valid),
	.finish       (finish)
);

// File: conv_cfg.svh
`ifndef CONV_CFG_SVH
`define CONV_CFG_SVH

// word width on the input bus, also coefficient, pixel and result width
`define CONV_DATA_W 16

// kernel side, 3x3 window
`define CONV_K_N 3

// image side, 7x7 pixels per frame
`define CONV_IMG_N 7

// full booth product width
`define CONV_PROD_W 32

// product bits kept below the sign bit
// 1.0 sits at bit 12, so 0x1000 x pixel gives the pixel back
`define CONV_TRUNC_HI 26
`define CONV_TRUNC_LO 12

`endif

// File: conv_checker.sv
`timescale 1ns/1ps
`include "conv_cfg.svh"

module conv_checker
	import conv_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	input  acc_t result,
	input  logic result_valid,
	input  logic finish,
	input  logic flush,
	output int   error_count,
	output int   result_count,
	output int   frames_done,
	output int   frames_failed
);

	localparam int k_n = `CONV_K_N;
	localparam int img_n = `CONV_IMG_N;
	localparam int out_n = img_n - k_n + 1;
	localparam int out_num = out_n * out_n;
	localparam int dw = `CONV_DATA_W;

	// expected results in arrival order, one name per pending frame
	acc_t exp_q [$];
	string name_q [$];
	acc_t exp_val;
	int frame_pos;
	int frame_errs;
	bit flushed;

	// full signed product, sign bit kept, then bits 26..12
	function automatic acc_t tap(input logic signed [15:0] c, input logic signed [15:0] p);
		logic signed [31:0] full;
		full = 32'(c) * 32'(p);
		tap = {full[31], full[26:12]};
	endfunction

	task automatic load_frame(input string name, input logic [k_n*k_n*dw-1:0] kernel,
		input logic [img_n*img_n*dw-1:0] image);
		acc_t sum;
		for (int r = 0; r < out_n; r++) begin
			for (int c = 0; c < out_n; c++) begin
				// nine taps, sum wraps at 16 bits
				sum = '0;
				for (int kr = 0; kr < k_n; kr++) begin
					for (int kc = 0; kc < k_n; kc++) begin
						sum += tap(kernel[(kr*k_n+kc)*dw +: dw],
							image[((r+kr)*img_n+c+kc)*dw +: dw]);
					end
				end
				exp_q.push_back(sum);
			end
		end
		name_q.push_back(name);
	endtask

	// negedge sampling, outputs settle after the rising edge
	always @(negedge clk) begin
		if (!rst_n) begin
			error_count = 0;
			result_count = 0;
			frames_done = 0;
			frames_failed = 0;
			frame_pos = 0;
			frame_errs = 0;
			flushed = 1'b0;
		end else begin
			if (result_valid) begin
				result_count++;
				if (exp_q.size() == 0) begin
					$display("extra result 0x%04h with no frame left to check", result);
					error_count++;
				end else begin
					exp_val = exp_q.pop_front();
					frame_pos++;
					if (result !== exp_val) begin
						$display("Mismatch %s result %0d: expected 0x%04h actual 0x%04h",
							name_q[0], frame_pos, exp_val, result);
						frame_errs++;
					end
					if (frame_pos == out_num && finish !== 1'b1) begin
						$display("%s: finish missing on the last result", name_q[0]);
						frame_errs++;
					end
					if (frame_pos != out_num && finish === 1'b1) begin
						$display("%s: finish raised on result %0d, before the last one",
							name_q[0], frame_pos);
						frame_errs++;
					end
					if (frame_pos == out_num) begin
						$display("test %s: %0d results, %0d errors, %s", name_q[0], out_num,
							frame_errs, (frame_errs == 0) ? "ok" : "bad");
						error_count += frame_errs;
						if (frame_errs != 0) begin
							frames_failed++;
						end
						frames_done++;
						void'(name_q.pop_front());
						frame_pos = 0;
						frame_errs = 0;
					end
				end
			end else if (finish === 1'b1) begin
				$display("finish raised without result_valid");
				error_count++;
			end
			// end of stimulus, anything still queued never came out
			if (flush && !flushed) begin
				flushed = 1'b1;
				if (exp_q.size() != 0) begin
					$display("wrong result count: %0d results never arrived, frame %s incomplete",
						exp_q.size(), name_q[0]);
					error_count++;
					frames_failed += name_q.size();
				end
			end
		end
	end

endmodule

// File: conv_pkg.sv
`include "conv_cfg.svh"

package conv_pkg;

	// raw word as seen on the req/ack bus
	typedef logic [`CONV_DATA_W-1:0] word_t;

	// kernel coefficient, same fixed point as the result
	// 1.0 is 0x1000
	typedef logic signed [`CONV_DATA_W-1:0] coef_t;

	// image pixel, signed
	typedef logic signed [`CONV_DATA_W-1:0] pixel_t;

	// truncated product or running sum, wraps modulo 2^16
	typedef logic [`CONV_DATA_W-1:0] acc_t;

	// full multiplier result before truncation
	typedef logic signed [`CONV_PROD_W-1:0] prod_t;

	// input sequencer states
	// st_idle waits for the first coefficient of a frame
	// st_wait holds ack until the producer drops req
	typedef enum logic [1:0] {
		st_idle,
		st_coef,
		st_pix,
		st_wait
	} seq_state_t;

endpackage

// File: conv_tb.sv
`timescale 1ns/1ps
`include "conv_cfg.svh"

module conv_tb
	import conv_pkg::*;
();

	localparam int n_tests = 7;
	localparam int clk_period = 40;
	localparam int drive_dly = 4;
	localparam int reset_cycles = 16;
	localparam int gap_max = 5;
	localparam int k_num = `CONV_K_N * `CONV_K_N;
	localparam int pix_num = `CONV_IMG_N * `CONV_IMG_N;
	localparam int words_per_frame = k_num + pix_num;
	localparam bit [31:0] seed = 32'hfdfc;
	// worst handshake is the longest gap, req to ack, ack release and one spare edge
	localparam int hs_cycles = gap_max + 3;
	localparam longint watchdog_ns =
		longint'(n_tests) * words_per_frame * hs_cycles * clk_period
		+ longint'(reset_cycles + 200) * clk_period;

	// kernel modes
	localparam int k_identity = 0;
	localparam int k_negative = 1;
	localparam int k_random = 2;
	localparam int k_smooth = 3;
	localparam int k_extreme = 4;
	// image modes
	localparam int i_ramp = 0;
	localparam int i_signed_ramp = 1;
	localparam int i_random = 2;
	localparam int i_extreme = 3;

	// mixed signs and sizes, 1.0 is 0x1000
	localparam word_t neg_kernel [9] = '{16'hf000, 16'hf800, 16'h0400, 16'he000, 16'h1000,
		16'hf400, 16'h0200, 16'he800, 16'hff00};
	// 1/16 binomial blur
	localparam word_t smooth_kernel [9] = '{16'h0100, 16'h0200, 16'h0100, 16'h0200, 16'h0400,
		16'h0200, 16'h0100, 16'h0200, 16'h0100};

	logic clk;
	logic rst_n;
	logic req;
	word_t data;
	logic ack;
	acc_t result;
	logic result_valid;
	logic finish;
	logic flush;
	int error_count;
	int result_count;
	int frames_done;
	int frames_failed;
	int assert_fails;

	// stimulus table
	string test_name [n_tests];
	int kern_mode [n_tests];
	int img_mode [n_tests];
	int max_gap [n_tests];

	conv3x3_engine u_conv3x3_engine (
		.clk          (clk),
		.rst_n        (rst_n),
		.req          (req),
		.data         (data),
		.ack          (ack),
		.result       (result),
		.result_valid (result_valid),
		.finish       (finish)
	);

	conv_checker u_conv_checker (
		.clk           (clk),
		.rst_n         (rst_n),
		.result        (result),
		.result_valid  (result_valid),
		.finish        (finish),
		.flush         (flush),
		.error_count   (error_count),
		.result_count  (result_count),
		.frames_done   (frames_done),
		.frames_failed (frames_failed)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	task automatic set_test(input int t, input string name, input int km, input int im,
		input int gap);
		test_name[t] = name;
		kern_mode[t] = km;
		img_mode[t] = im;
		max_gap[t] = gap;
	endtask

	function automatic word_t kernel_word(input int mode, input int k);
		case (mode)
			k_identity: kernel_word = (k == 4) ? 16'h1000 : 16'h0000;
			k_negative: kernel_word = neg_kernel[k];
			k_smooth: kernel_word = smooth_kernel[k];
			k_extreme: kernel_word = (k % 2 == 0) ? 16'h8000 : 16'h7fff;
			default: kernel_word = word_t'($urandom);
		endcase
	endfunction

	function automatic word_t image_word(input int mode, input int idx);
		case (mode)
			i_ramp: image_word = word_t'(idx * 16'h0111);
			// crosses zero in the middle row
			i_signed_ramp: image_word = word_t'((idx - 24) * 256);
			i_extreme: image_word = ((idx / 7 + idx % 7) % 2 == 0) ? 16'h8000 : 16'h7fff;
			default: image_word = word_t'($urandom);
		endcase
	endfunction

	// one four-phase transfer, optional idle cycles first
	task automatic send_word(input word_t w, input int gap_limit);
		int gap;
		gap = 0;
		if (gap_limit > 0) begin
			gap = $urandom_range(gap_limit, 0);
		end
		repeat (gap) begin
			@(posedge clk);
			#drive_dly;
		end
		data = w;
		req = 1'b1;
		do begin
			@(posedge clk);
			#drive_dly;
		end while (!ack);
		req = 1'b0;
		do begin
			@(posedge clk);
			#drive_dly;
		end while (ack);
	endtask

	// kernel first, then the image in raster order
	task automatic run_test(input int t);
		logic [k_num*`CONV_DATA_W-1:0] kernel;
		logic [pix_num*`CONV_DATA_W-1:0] image;
		for (int k = 0; k < k_num; k++) begin
			kernel[k*`CONV_DATA_W +: `CONV_DATA_W] = kernel_word(kern_mode[t], k);
		end
		for (int i = 0; i < pix_num; i++) begin
			image[i*`CONV_DATA_W +: `CONV_DATA_W] = image_word(img_mode[t], i);
		end
		u_conv_checker.load_frame(test_name[t], kernel, image);
		for (int k = 0; k < k_num; k++) begin
			send_word(kernel[k*`CONV_DATA_W +: `CONV_DATA_W], max_gap[t]);
		end
		for (int i = 0; i < pix_num; i++) begin
			send_word(image[i*`CONV_DATA_W +: `CONV_DATA_W], max_gap[t]);
		end
	endtask

	initial begin
		void'($urandom(seed));
		rst_n = 1'b0;
		req = 1'b0;
		data = '0;
		flush = 1'b0;
		set_test(0, "identity", k_identity, i_ramp, 0);
		set_test(1, "negative_ramp", k_negative, i_signed_ramp, 0);
		set_test(2, "random", k_random, i_random, 0);
		set_test(3, "back_to_back_a", k_random, i_random, 0);
		set_test(4, "back_to_back_b", k_smooth, i_random, 0);
		set_test(5, "extreme", k_extreme, i_extreme, 0);
		set_test(6, "random_gaps", k_random, i_random, gap_max);
		repeat (reset_cycles) @(posedge clk);
		#drive_dly;
		rst_n = 1'b1;
		@(posedge clk);
		#drive_dly;
		// frames go back to back, no pause between tests
		for (int t = 0; t < n_tests; t++) begin
			run_test(t);
		end
		// last result lands two edges after the final ack
		for (int w = 0; w < 20 && frames_done < n_tests; w++) begin
			@(posedge clk);
			#drive_dly;
		end
		flush = 1'b1;
		repeat (2) @(posedge clk);
		// handshake and output rules checked in the bound instances
		assert_fails = u_conv3x3_engine.u_load_sequencer.u_seq_assertions.fail_count
			+ u_conv3x3_engine.u_mac_tree.u_mac_assertions.fail_count;
		$display("tests: %0d run, %0d failed; results: %0d; errors: %0d; assertions: %0d",
			n_tests, frames_failed, result_count, error_count, assert_fails);
		if (error_count == 0 && assert_fails == 0 && frames_done == n_tests) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

	initial begin : watchdog
		#(watchdog_ns);
		$display("timeout: run still busy after %0d ns, %0d of %0d frames checked",
			watchdog_ns, frames_done, n_tests);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// File: conv_window_if.sv
`timescale 1ns/1ps
`include "conv_cfg.svh"

// kernel and current 3x3 window, window buffer to mac tree
interface conv_window_if
	import conv_pkg::*;
();

	// both arrays are row-major, index r*K_N+c
	coef_t coef [`CONV_K_N*`CONV_K_N];
	pixel_t pix [`CONV_K_N*`CONV_K_N];

	// one-cycle strobe, window holds a full in-image neighbourhood
	logic win_valid;

	// marks the last window of the frame, only together with win_valid
	logic win_last;

	modport src (
		output coef,
		output pix,
		output win_valid,
		output win_last
	);

	modport dst (
		input coef,
		input pix,
		input win_valid,
		input win_last
	);

endinterface

// File: load_sequencer.sv
`timescale 1ns/1ps
`include "conv_cfg.svh"

module load_sequencer
	import conv_pkg::*;
(
	input  logic  clk,
	input  logic  rst_n,
	input  logic  req,
	input  word_t data,
	output logic  ack,
	output word_t word,
	output logic  coef_we,
	output logic  pix_we
);

	// words per frame section
	localparam int coef_num = `CONV_K_N * `CONV_K_N;
	localparam int pix_num = `CONV_IMG_N * `CONV_IMG_N;
	localparam int coef_cnt_w = $clog2(coef_num + 1);
	localparam int pix_cnt_w = $clog2(pix_num + 1);

	seq_state_t state;
	logic [coef_cnt_w-1:0] coef_cnt;
	logic [pix_cnt_w-1:0] pix_cnt;

	// new word offered while not still waiting for release
	logic take;

	assign take = req && (state != st_wait);

	// payload capture, valid only when a strobe follows
	always_ff @(posedge clk) begin
		if (take) begin
			word <= data;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_idle;
			ack <= 1'b0;
			coef_we <= 1'b0;
			pix_we <= 1'b0;
			coef_cnt <= '0;
			pix_cnt <= '0;
		end else begin
			// strobes last one cycle, aligned with ack rise
			coef_we <= 1'b0;
			pix_we <= 1'b0;
			case (state)
				st_idle: begin
					// first coefficient restarts both counters
					if (req) begin
						ack <= 1'b1;
						coef_we <= 1'b1;
						coef_cnt <= coef_cnt_w'(1);
						pix_cnt <= '0;
						state <= st_wait;
					end
				end
				st_coef: begin
					if (req) begin
						ack <= 1'b1;
						coef_we <= 1'b1;
						coef_cnt <= coef_cnt + 1'b1;
						state <= st_wait;
					end
				end
				st_pix: begin
					if (req) begin
						ack <= 1'b1;
						pix_we <= 1'b1;
						pix_cnt <= pix_cnt + 1'b1;
						state <= st_wait;
					end
				end
				st_wait: begin
					// release phase, ack drops once req is seen low
					if (!req) begin
						ack <= 1'b0;
						if (pix_cnt == pix_cnt_w'(pix_num)) begin
							// frame complete, next word is a coefficient
							state <= st_idle;
						end else if (coef_cnt == coef_cnt_w'(coef_num)) begin
							state <= st_pix;
						end else begin
							state <= st_coef;
						end
					end
				end
				default: begin
					state <= st_idle;
					ack <= 1'b0;
				end
			endcase
		end
	end

endmodule

// File: mac_tree.sv
`timescale 1ns/1ps
`include "conv_cfg.svh"

module mac_tree
	import conv_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	conv_window_if.dst win,
	output acc_t result,
	output logic result_valid,
	output logic finish
);

	localparam int k_n = `CONV_K_N;
	localparam int k_num = k_n * k_n;

	acc_t prod [k_num];
	acc_t row_sum [k_n];
	acc_t total;

	// one multiplier per window tap
	for (genvar k = 0; k < k_num; k++) begin : g_mul
		booth_multiplier u_booth_multiplier (
			.a (win.coef[k]),
			.b (win.pix[k]),
			.p (prod[k])
		);
	end

	// first level, one three-input add per window row
	always_comb begin
		for (int r = 0; r < k_n; r++) begin
			row_sum[r] = prod[r*k_n] + prod[r*k_n+1] + prod[r*k_n+2];
		end
	end

	// second level, overflow simply wraps
	assign total = row_sum[0] + row_sum[1] + row_sum[2];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			result <= '0;
			result_valid <= 1'b0;
			finish <= 1'b0;
		end else begin
			result_valid <= win.win_valid;
			// win_last comes only with the strobe of the 25th window
			finish <= win.win_last;
			// hold last result between windows
			if (win.win_valid) begin
				result <= total;
			end
		end
	end

endmodule

// File: window_buffer.sv
`timescale 1ns/1ps
`include "conv_cfg.svh"

module window_buffer
	import conv_pkg::*;
#(
	parameter int img_n = `CONV_IMG_N
) (
	input  logic  clk,
	input  logic  rst_n,
	input  word_t word,
	input  logic  coef_we,
	input  logic  pix_we,
	conv_window_if.src win
);

	localparam int k_n = `CONV_K_N;
	localparam int k_num = k_n * k_n;
	localparam int cnt_w = $clog2(img_n);

	// two rows of history, tail is the same column one and two rows up
	pixel_t line1 [img_n];
	pixel_t line2 [img_n];

	// position of the incoming pixel
	logic [cnt_w-1:0] row;
	logic [cnt_w-1:0] col;

	always_ff @(posedge clk) begin
		// coefficients arrive row-major, first one ends up at index 0
		if (coef_we) begin
			for (int k = 0; k < k_num - 1; k++) begin
				win.coef[k] <= win.coef[k+1];
			end
			win.coef[k_num-1] <= coef_t'(word);
		end
		if (pix_we) begin
			line1[0] <= pixel_t'(word);
			line2[0] <= line1[img_n-1];
			for (int i = 1; i < img_n; i++) begin
				line1[i] <= line1[i-1];
				line2[i] <= line2[i-1];
			end
			// window slides one column left
			for (int r = 0; r < k_n; r++) begin
				for (int c = 0; c < k_n - 1; c++) begin
					win.pix[r*k_n+c] <= win.pix[r*k_n+c+1];
				end
			end
			// new right column, oldest row on top
			win.pix[k_n-1] <= line2[img_n-1];
			win.pix[2*k_n-1] <= line1[img_n-1];
			win.pix[k_num-1] <= pixel_t'(word);
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			row <= '0;
			col <= '0;
			win.win_valid <= 1'b0;
			win.win_last <= 1'b0;
		end else begin
			// edge columns and top rows hold wrapped data, not a window
			win.win_valid <= pix_we && (row >= cnt_w'(k_n - 1)) && (col >= cnt_w'(k_n - 1));
			win.win_last <= pix_we && (row == cnt_w'(img_n - 1)) && (col == cnt_w'(img_n - 1));
			if (pix_we) begin
				if (col == cnt_w'(img_n - 1)) begin
					col <= '0;
					// wraps with the frame, matches the sequencer pixel count
					if (row == cnt_w'(img_n - 1)) begin
						row <= '0;
					end else begin
						row <= row + 1'b1;
					end
				end else begin
					col <= col + 1'b1;
				end
			end
		end
	end

endmodule
